// File: compile.f
common/ppu_pkg.sv
rtl/lcd_timing.sv
rtl/ppu_regs.sv
rtl/vram.sv
rtl/bg_render/bg_fetcher.sv
rtl/bg_render/pixel_fifo.sv
rtl/ppu_top.sv
verification/tb_ppu.sv

// File: run_sim.sh
#!/bin/sh
# Build tb_ppu with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ppu \
    -f compile.f -o tb_ppu > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_ppu > sim.log 2>&1
cat sim.log
grep -qx "Test OK" sim.log && exit 0 || exit 1

// File: verification/tb_ppu.sv
`timescale 1ns/1ps

module tb_ppu
    import ppu_pkg::*;
();

    localparam int LINE_CYCLES  = 456;
    localparam int FRAME_CYCLES = 456 * 154;
    localparam int SIG_HS       = 0;
    localparam int SIG_VS       = 1;
    localparam int SIG_VBLANK   = 2;
    localparam int SIG_LCDC     = 3;

    logic        clk;
    logic        rst;
    logic [15:0] a;
    logic [7:0]  d_wr;
    logic        rd;
    logic        wr;
    logic        int_vblank_ack;
    logic        int_lcdc_ack;
    logic [7:0]  d_rd;
    logic        int_vblank_req;
    logic        int_lcdc_req;
    logic [1:0]  pixel;
    logic        valid;
    logic        hs;
    logic        vs;

    ppu_top u_ppu_top (
        .clk            (clk),
        .rst            (rst),
        .a              (a),
        .d_wr           (d_wr),
        .rd             (rd),
        .wr             (wr),
        .int_vblank_ack (int_vblank_ack),
        .int_lcdc_ack   (int_lcdc_ack),
        .d_rd           (d_rd),
        .int_vblank_req (int_vblank_req),
        .int_lcdc_req   (int_lcdc_req),
        .pixel          (pixel),
        .valid          (valid),
        .hs             (hs),
        .vs             (vs)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Inputs change 10 ns after the edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected)
            abort_run($sformatf("Error at %0t ns: %s: got 0x%0h, expected 0x%0h",
                                $time, what, actual, expected));
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        a    = addr;
        d_wr = data;
        wr   = 1'b1;
        step();
        wr   = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        a  = addr;
        rd = 1'b1;
        step();
        rd   = 1'b0;
        data = d_rd; // Registered read, valid right after the edge
    endtask

    task automatic pulse_ack(input logic vblank, input logic lcdc);
        int_vblank_ack = vblank;
        int_lcdc_ack   = lcdc;
        step();
        int_vblank_ack = 1'b0;
        int_lcdc_ack   = 1'b0;
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            SIG_HS:     return hs;
            SIG_VS:     return vs;
            SIG_VBLANK: return int_vblank_req;
            default:    return int_lcdc_req;
        endcase
    endfunction

    function automatic string sig_name(input int sel);
        case (sel)
            SIG_HS:     return "hs";
            SIG_VS:     return "vs";
            SIG_VBLANK: return "int_vblank_req";
            default:    return "int_lcdc_req";
        endcase
    endfunction

    // Returns the cycles from the call to the first sample after a 0 to 1 change
    task automatic wait_rise(input int sel, input int limit, output int cycles);
        logic prev;
        prev   = probe(sel);
        step();
        cycles = 1;
        while (!(probe(sel) && !prev))
        begin
            if (cycles >= limit)
                abort_run($sformatf("Timeout waiting for %s to rise", sig_name(sel)));
            prev = probe(sel);
            step();
            cycles++;
        end
    endtask

    task automatic count_high(input int sel, input int limit, output int cycles);
        cycles = 0;
        while (probe(sel))
        begin
            if (cycles >= limit)
                abort_run($sformatf("%s stayed high too long", sig_name(sel)));
            step();
            cycles++;
        end
    endtask

    // Shade of every pixel on a line, from the tile pattern loaded in the pixel test
    function automatic logic [1:0] expected_shade(input int line, input logic [7:0] scy,
                                                  input logic map_hi, input logic [7:0] bgp);
        logic [7:0] map_line;
        logic [1:0] id;
        logic [7:0] shade;
        map_line = 8'(line) + scy;
        if (map_hi)
            id = 2'd0; // Tile 1 is blank
        else if (map_line[2:0] == 3'd0)
            id = 2'd2;
        else
            id = 2'd1;
        shade = bgp >> (2 * id);
        return shade[1:0];
    endfunction

    task automatic check_line(input logic [1:0] shade, input int line);
        int n;
        int i;
        n = 0;
        while (!valid)
        begin
            if (n >= 2 * LINE_CYCLES)
                abort_run($sformatf("Timeout waiting for pixels of line %0d", line));
            step();
            n++;
        end
        for (i = 0; i < 160; i++)
        begin
            check_eq(valid, 1'b1, $sformatf("valid on line %0d x %0d", line, i));
            check_eq(pixel, shade, $sformatf("pixel on line %0d x %0d", line, i));
            step();
        end
        check_eq(valid, 1'b0, $sformatf("valid after 160 pixels on line %0d", line));
    endtask

    // Restart the LCD with a new scroll and map, then check lines 0 and 1
    task automatic check_frame(input logic [7:0] scy, input logic map_hi);
        int line;
        bus_write(ADDR_LCDC, 8'h00);
        bus_write(ADDR_SCY, scy);
        bus_write(ADDR_LCDC, map_hi ? 8'h99 : 8'h91);
        for (line = 0; line < 2; line++)
            check_line(expected_shade(line, scy, map_hi, 8'hE4), line);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic test_registers();
        logic [7:0] val;
        bus_read(ADDR_BGP, val);
        check_eq(val, 8'hFC, "BGP reset value");
        bus_write(ADDR_LCDC, 8'h56); // LCD stays off
        bus_write(ADDR_SCY, 8'h33);
        bus_write(ADDR_LYC, 8'h21);
        bus_write(ADDR_BGP, 8'hE4);
        bus_read(ADDR_LCDC, val);
        check_eq(val, 8'h56, "LCDC readback");
        bus_read(ADDR_SCY, val);
        check_eq(val, 8'h33, "SCY readback");
        bus_read(ADDR_LYC, val);
        check_eq(val, 8'h21, "LYC readback");
        bus_read(ADDR_BGP, val);
        check_eq(val, 8'hE4, "BGP readback");
        bus_write(ADDR_LY, 8'h55);
        bus_read(ADDR_LY, val);
        check_eq(val, 8'h00, "LY after a write");
        // Status bits keep LY != LYC and mode VBLANK
        bus_write(ADDR_STAT, 8'hFF);
        bus_read(ADDR_STAT, val);
        check_eq(val, 8'hF9, "STAT after a write");
        bus_write(ADDR_STAT, 8'h00);
        bus_read(16'hFF43, val);
        check_eq(val, 8'hFF, "unmapped read");
    endtask

    task automatic test_vram();
        logic [7:0] val;
        int n;
        bus_write(ADDR_LCDC, 8'h00);
        bus_write(16'h8000, 8'h5A);
        bus_write(16'h8ABC, 8'hC3);
        bus_write(16'h9FFF, 8'h81);
        bus_read(16'h8000, val);
        check_eq(val, 8'h5A, "VRAM 0x8000");
        bus_read(16'h8ABC, val);
        check_eq(val, 8'hC3, "VRAM 0x8ABC");
        bus_read(16'h9FFF, val);
        check_eq(val, 8'h81, "VRAM 0x9FFF");
        bus_write(ADDR_LCDC, 8'h91);
        n = 0;
        bus_read(ADDR_STAT, val);
        while (val[1:0] != 2'd3)
        begin
            if (n >= 2 * LINE_CYCLES)
                abort_run("Timeout waiting for STAT to report pixel transfer");
            bus_read(ADDR_STAT, val);
            n++;
        end
        bus_read(16'h8000, val);
        check_eq(val, 8'hFF, "VRAM read during XFER");
        n = 0;
        bus_read(ADDR_STAT, val);
        while (val[1:0] != 2'd0)
        begin
            if (n >= 2 * LINE_CYCLES)
                abort_run("Timeout waiting for STAT to report HBLANK");
            bus_read(ADDR_STAT, val);
            n++;
        end
        bus_read(16'h8000, val);
        check_eq(val, 8'h5A, "VRAM read during HBLANK");
        bus_write(ADDR_LCDC, 8'h00);
    endtask

    task automatic test_sync();
        int n;
        bus_write(ADDR_LCDC, 8'h91);
        wait_rise(SIG_HS, 2 * LINE_CYCLES, n);
        wait_rise(SIG_HS, 2 * LINE_CYCLES, n);
        check_eq(n, LINE_CYCLES, "hs period");
        count_high(SIG_HS, LINE_CYCLES, n);
        check_eq(n, 4, "hs width");
        wait_rise(SIG_VS, FRAME_CYCLES + LINE_CYCLES, n);
        count_high(SIG_VS, 2 * LINE_CYCLES, n);
        check_eq(n, LINE_CYCLES, "vs width");
        wait_rise(SIG_VS, FRAME_CYCLES + LINE_CYCLES, n);
        check_eq(n + LINE_CYCLES, FRAME_CYCLES, "vs period"); // Measured from the falling edge
    endtask

    task automatic test_pixels();
        int i;
        bus_write(ADDR_LCDC, 8'h00);
        // First two map rows of both maps
        for (i = 0; i < 64; i++)
        begin
            bus_write(16'h9800 + 16'(i), 8'h00);
            bus_write(16'h9C00 + 16'(i), 8'h01);
        end
        for (i = 0; i < 16; i += 2)
        begin
            bus_write(16'h8000 + 16'(i), (i == 0) ? 8'hFF : 8'h00); // Low byte
            bus_write(16'h8001 + 16'(i), (i == 0) ? 8'h00 : 8'hFF); // High byte
        end
        for (i = 0; i < 16; i++)
            bus_write(16'h8010 + 16'(i), 8'h00);
        bus_write(ADDR_BGP, 8'hE4);
        check_frame(8'd0, 1'b0);
        check_frame(8'd7, 1'b0);
        check_frame(8'd0, 1'b1);
    endtask

    task automatic test_interrupts();
        logic [7:0] val;
        int n;
        pulse_ack(1'b1, 1'b1); // Drop anything left from earlier frames
        wait_rise(SIG_VBLANK, FRAME_CYCLES + LINE_CYCLES, n);
        pulse_ack(1'b1, 1'b0);
        check_eq(int_vblank_req, 1'b0, "int_vblank_req after ack");
        wait_rise(SIG_VBLANK, FRAME_CYCLES + LINE_CYCLES, n);
        check_eq(n + 1, FRAME_CYCLES, "vblank request period");

        bus_write(ADDR_LYC, 8'd5);
        bus_write(ADDR_STAT, 8'h40); // Coincidence source only
        pulse_ack(1'b0, 1'b1);
        wait_rise(SIG_LCDC, FRAME_CYCLES + LINE_CYCLES, n);
        bus_read(ADDR_LY, val);
        check_eq(val, 8'd5, "LY at coincidence");
        bus_read(ADDR_STAT, val);
        check_eq(val[2], 1'b1, "STAT coincidence bit on line 5");
        check_eq(val[6], 1'b1, "STAT coincidence select");
        pulse_ack(1'b0, 1'b1);
        check_eq(int_lcdc_req, 1'b0, "int_lcdc_req after ack");
        n = 0;
        bus_read(ADDR_LY, val);
        while (val == 8'd5)
        begin
            if (n >= 2 * LINE_CYCLES)
                abort_run("Timeout waiting for LY to leave line 5");
            bus_read(ADDR_LY, val);
            n++;
        end
        check_eq(val, 8'd6, "LY after line 5");
        bus_read(ADDR_STAT, val);
        check_eq(val[2], 1'b0, "STAT coincidence bit on line 6");
        bus_write(ADDR_STAT, 8'h00);
    endtask

    //////////////////////////////
    // Sequence
    //////////////////////////////
    initial
    begin
        rst            = 1'b1;
        a              = '0;
        d_wr           = '0;
        rd             = 1'b0;
        wr             = 1'b0;
        int_vblank_ack = 1'b0;
        int_lcdc_ack   = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        check_eq(valid, 1'b0, "valid after reset");
        check_eq(hs, 1'b0, "hs after reset");
        check_eq(vs, 1'b0, "vs after reset");
        check_eq(int_vblank_req, 1'b0, "int_vblank_req after reset");
        check_eq(int_lcdc_req, 1'b0, "int_lcdc_req after reset");

        test_registers();
        test_vram();
        test_sync();
        test_pixels();
        test_interrupts();

        $display("Test OK");
        $finish;
    end

endmodule

// File: rtl/ppu_top.sv
`timescale 1ns/1ps

module ppu_top
    import ppu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] a,
    input  logic [7:0]  d_wr,
    input  logic        rd,
    input  logic        wr,
    input  logic        int_vblank_ack,
    input  logic        int_lcdc_ack,
    output logic [7:0]  d_rd,
    output logic        int_vblank_req,
    output logic        int_lcdc_req,
    output logic [1:0]  pixel,
    output logic        valid,
    output logic        hs,
    output logic        vs
);

    bus_req_t   bus;
    ppu_cfg_t   cfg;
    line_pos_t  pos;
    tile_row_t  row;
    logic       vram_we;
    logic       vram_re;
    logic [12:0] vram_offset;
    logic [7:0] vram_rdata;
    logic [12:0] fetch_addr;
    logic [7:0] fetch_rdata;
    logic       shift;

    assign bus = '{addr: a, wdata: d_wr, rd: rd, wr: wr};

    ppu_regs u_ppu_regs (
        .clk            (clk),
        .rst            (rst),
        .bus            (bus),
        .pos            (pos),
        .vram_rdata     (vram_rdata),
        .int_vblank_ack (int_vblank_ack),
        .int_lcdc_ack   (int_lcdc_ack),
        .cfg            (cfg),
        .vram_we        (vram_we),
        .vram_re        (vram_re),
        .vram_offset    (vram_offset),
        .d_rd           (d_rd),
        .int_vblank_req (int_vblank_req),
        .int_lcdc_req   (int_lcdc_req)
    );

    lcd_timing u_lcd_timing (
        .clk    (clk),
        .rst    (rst),
        .lcd_en (cfg.lcdc.lcd_en),
        .pos    (pos),
        .hs     (hs),
        .vs     (vs)
    );

    vram u_vram (
        .clk         (clk),
        .mode        (pos.mode),
        .cpu_we      (vram_we),
        .cpu_re      (vram_re),
        .cpu_offset  (vram_offset),
        .cpu_wdata   (bus.wdata),
        .fetch_addr  (fetch_addr),
        .cpu_rdata   (vram_rdata),
        .fetch_rdata (fetch_rdata)
    );

    bg_fetcher u_bg_fetcher (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .pos         (pos),
        .fetch_rdata (fetch_rdata),
        .fetch_addr  (fetch_addr),
        .row         (row),
        .shift       (shift)
    );

    pixel_fifo u_pixel_fifo (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg),
        .row   (row),
        .shift (shift),
        .pixel (pixel),
        .valid (valid)
    );

endmodule

// File: rtl/bg_render/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo
    import ppu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  ppu_cfg_t  cfg,
    input  tile_row_t row,
    input  logic      shift,
    output logic [1:0] pixel,
    output logic      valid
);

    logic [15:0][1:0] fifo;  // Entry 15 leaves first
    logic [7:0][1:0]  ids;
    logic [1:0]       head_id;
    logic [7:0]       cnt;   // Shifts since the start of XFER

    // Low-byte bit is the upper id bit, bit 7 is the leftmost pixel
    always_comb
    begin
        for (int i = 0; i < 8; i++)
            ids[i] = {row.data_lo[i], row.data_hi[i]};
    end

    assign head_id = cfg.lcdc.bg_en ? fifo[15] : 2'b00;

    always_ff @(posedge clk)
    begin
        if (shift)
        begin
            fifo  <= row.load ? {fifo[14:7], ids} : {fifo[14:0], 2'b00};
            pixel <= cfg.bgp[{head_id, 1'b0} +: 2]; // BGP lookup
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt   <= '0;
            valid <= 1'b0;
        end
        else
        begin
            valid <= shift && (cnt >= FIFO_DEPTH) && (cnt < FIFO_DEPTH + VISIBLE_PIX);
            if (!shift)
                cnt <= '0; // New line
            else if (cnt < FIFO_DEPTH + VISIBLE_PIX)
                cnt <= cnt + 8'd1;
        end
    end

endmodule

// File: rtl/bg_render/bg_fetcher.sv
`timescale 1ns/1ps

module bg_fetcher
    import ppu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ppu_cfg_t    cfg,
    input  line_pos_t   pos,
    input  logic [7:0]  fetch_rdata,
    output logic [12:0] fetch_addr,
    output tile_row_t   row,
    output logic        shift
);

    logic [2:0]  step;    // 0..7 for fetch steps 1..8
    logic [4:0]  tile_x;
    logic [7:0]  tile_id;
    logic [7:0]  data_lo;
    logic [7:0]  data_hi;
    logic        xfer;
    logic [7:0]  bg_line; // Line within the 256-line map
    logic [12:0] map_base;
    logic [12:0] tile_base;
    logic [12:0] map_addr;
    logic [12:0] lo_addr;

    assign xfer      = (pos.mode == XFER);
    assign bg_line   = pos.v_count + cfg.scy;
    assign map_base  = cfg.lcdc.bg_map ? MAP_BASE_HI : MAP_BASE_LO;
    assign tile_base = cfg.lcdc.tile_sel ? TILE_BASE_HI : TILE_BASE_LO;
    assign map_addr  = map_base + {3'b000, bg_line[7:3], tile_x};
    assign lo_addr   = tile_base + {1'b0, tile_id, bg_line[2:0], 1'b0};

    // VRAM data arrives the step after its address
    always_comb
    begin
        case (step)
            3'd0, 3'd1: fetch_addr = map_addr;
            3'd2, 3'd3: fetch_addr = lo_addr;
            default:    fetch_addr = {lo_addr[12:1], 1'b1}; // High byte
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || !xfer)
        begin
            step   <= '0;
            tile_x <= '0;
        end
        else if (step == TILE_STEPS - 1)
        begin
            step   <= '0;
            tile_x <= tile_x + 5'd1;
        end
        else
        begin
            step <= step + 3'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (xfer)
        begin
            case (step)
                3'd1:    tile_id <= fetch_rdata;
                3'd3:    data_lo <= fetch_rdata;
                3'd5:    data_hi <= fetch_rdata;
                default: ;
            endcase
        end
    end

    assign row.load    = xfer && (step == TILE_STEPS - 1);
    assign row.data_lo = data_lo;
    assign row.data_hi = data_hi;
    assign shift       = xfer; // No stalls without sprites

endmodule

// File: rtl/vram.sv
`timescale 1ns/1ps

module vram
    import ppu_pkg::*;
(
    input  logic        clk,
    input  ppu_mode_t   mode,
    input  logic        cpu_we,
    input  logic        cpu_re,
    input  logic [12:0] cpu_offset,
    input  logic [7:0]  cpu_wdata,
    input  logic [12:0] fetch_addr,
    output logic [7:0]  cpu_rdata,
    output logic [7:0]  fetch_rdata
);

    logic [7:0]  mem [8192];
    logic        xfer;
    logic [12:0] port_addr;

    // Fetcher owns the single port during pixel transfer
    assign xfer      = (mode == XFER);
    assign port_addr = xfer ? fetch_addr : cpu_offset;

    always_ff @(posedge clk)
    begin
        if (cpu_we && !xfer)
            mem[port_addr] <= cpu_wdata;
        fetch_rdata <= mem[port_addr];
        if (cpu_re)
            cpu_rdata <= xfer ? 8'hFF : mem[port_addr]; // Blocked read
    end

endmodule

// File: rtl/ppu_regs.sv
`timescale 1ns/1ps

module ppu_regs
    import ppu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  bus_req_t    bus,
    input  line_pos_t   pos,
    input  logic [7:0]  vram_rdata,
    input  logic        int_vblank_ack,
    input  logic        int_lcdc_ack,
    output ppu_cfg_t    cfg,
    output logic        vram_we,
    output logic        vram_re,
    output logic [12:0] vram_offset,
    output logic [7:0]  d_rd,
    output logic        int_vblank_req,
    output logic        int_lcdc_req
);

    lcdc_t      lcdc;
    logic [7:3] stat_ie;   // STAT interrupt selects, bit 7 only stored
    logic [7:0] scy;
    logic [7:0] lyc;
    logic [7:0] bgp;
    logic [7:0] ly;
    logic       coin;      // STAT bit 2
    ppu_mode_t  stat_mode; // STAT bits 1..0
    logic [7:0] rd_data_q;
    logic       rd_vram_q;
    logic       in_vram;
    logic       coin_next;
    logic       vblank_set;
    logic       lcdc_set;

    assign in_vram     = (bus.addr >= VRAM_LO) && (bus.addr <= VRAM_HI);
    assign vram_we     = bus.wr && in_vram;
    assign vram_re     = bus.rd && in_vram;
    assign vram_offset = bus.addr[12:0];

    assign cfg = '{lcdc: lcdc, scy: scy, bgp: bgp};

    //////////////////////////////
    // Register writes
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lcdc    <= '0;
            stat_ie <= '0;
            scy     <= '0;
            lyc     <= '0;
            bgp     <= BGP_RESET;
        end
        else if (bus.wr)
        begin
            case (bus.addr)
                ADDR_LCDC: lcdc    <= lcdc_t'(bus.wdata);
                ADDR_STAT: stat_ie <= bus.wdata[7:3]; // Low bits are status
                ADDR_SCY:  scy     <= bus.wdata;
                ADDR_LYC:  lyc     <= bus.wdata;
                ADDR_BGP:  bgp     <= bus.wdata;
                default:   ;
            endcase
        end
    end

    //////////////////////////////
    // Bus reads
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
            rd_vram_q <= 1'b0;
        else if (bus.rd)
            rd_vram_q <= in_vram;
    end

    always_ff @(posedge clk)
    begin
        if (bus.rd)
        begin
            case (bus.addr)
                ADDR_LCDC: rd_data_q <= lcdc;
                ADDR_STAT: rd_data_q <= {stat_ie, coin, stat_mode};
                ADDR_SCY:  rd_data_q <= scy;
                ADDR_LY:   rd_data_q <= ly;
                ADDR_LYC:  rd_data_q <= lyc;
                ADDR_BGP:  rd_data_q <= bgp;
                default:   rd_data_q <= 8'hFF;
            endcase
        end
    end

    // VRAM holds its own read data until the next VRAM read
    assign d_rd = rd_vram_q ? vram_rdata : rd_data_q;

    //////////////////////////////
    // LY, STAT and interrupts
    //////////////////////////////
    assign coin_next  = (pos.v_count == lyc);
    assign vblank_set = (pos.mode == VBLANK) && (stat_mode != VBLANK);
    assign lcdc_set   = (stat_ie[6] && coin_next && !coin)
                     || (stat_ie[5] && pos.mode == OAM_SEARCH && stat_mode != OAM_SEARCH)
                     || (stat_ie[4] && vblank_set)
                     || (stat_ie[3] && pos.mode == HBLANK && stat_mode != HBLANK);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ly             <= '0;
            coin           <= 1'b0;
            stat_mode      <= VBLANK;
            int_vblank_req <= 1'b0;
            int_lcdc_req   <= 1'b0;
        end
        else
        begin
            ly        <= pos.v_count; // One cycle behind the counters
            coin      <= coin_next;
            stat_mode <= pos.mode;
            if (vblank_set)
                int_vblank_req <= 1'b1;
            if (lcdc_set)
                int_lcdc_req <= 1'b1;
            if (int_vblank_ack)
                int_vblank_req <= 1'b0; // Ack wins
            if (int_lcdc_ack)
                int_lcdc_req <= 1'b0;
        end
    end

    // An acknowledged request is low in the next cycle, even with a new set pending
    a_vblank_ack_wins: assert property (@(posedge clk) disable iff (rst)
        int_vblank_ack |=> !int_vblank_req);
    a_lcdc_ack_wins: assert property (@(posedge clk) disable iff (rst)
        int_lcdc_ack |=> !int_lcdc_req);

endmodule

// File: rtl/lcd_timing.sv
`timescale 1ns/1ps

module lcd_timing
    import ppu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      lcd_en,
    output line_pos_t pos,
    output logic      hs,
    output logic      vs
);

    logic       run;  // Set once the first dot of line 0 is shown
    logic [8:0] h_nx;
    logic [7:0] v_nx;

    function automatic ppu_mode_t mode_of(input logic [8:0] h, input logic [7:0] v);
        if (v >= V_ACTIVE)
            return VBLANK;
        else if (h < OAM_LEN)
            return OAM_SEARCH;
        else if (h < OAM_LEN + XFER_LEN)
            return XFER;
        else
            return HBLANK;
    endfunction

    // Next dot and line
    always_comb
    begin
        h_nx = pos.h_count;
        v_nx = pos.v_count;
        if (!run)
        begin
            h_nx = '0; // Start at dot 0 of line 0
            v_nx = '0;
        end
        else if (pos.h_count == H_TOTAL - 16'd1)
        begin
            h_nx = '0;
            v_nx = (pos.v_count == V_TOTAL - 8'd1) ? 8'd0 : pos.v_count + 8'd1;
        end
        else
        begin
            h_nx = pos.h_count + 9'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || !lcd_en)
        begin
            run         <= 1'b0;
            pos.h_count <= '0;
            pos.v_count <= '0;
            pos.mode    <= VBLANK; // Reported while the LCD is off
            hs          <= 1'b0;
            vs          <= 1'b0;
        end
        else
        begin
            run         <= 1'b1;
            pos.h_count <= h_nx;
            pos.v_count <= v_nx;
            pos.mode    <= mode_of(h_nx, v_nx);
            hs          <= (h_nx >= H_SYNC_START) && (h_nx < H_SYNC_START + H_SYNC_LEN);
            vs          <= (v_nx == V_SYNC_START); // Whole last line
        end
    end

    a_h_in_range: assert property (@(posedge clk) disable iff (rst)
        pos.h_count < H_TOTAL);

endmodule

// File: common/ppu_pkg.sv
package ppu_pkg;

    //////////////////////////////
    // Display timing
    //////////////////////////////
    localparam logic [15:0] H_TOTAL      = 16'd456; // Dots per line
    localparam logic [15:0] H_SYNC_START = 16'd76;
    localparam logic [15:0] H_SYNC_LEN   = 16'd4;
    localparam logic [15:0] OAM_LEN      = 16'd80;  // Mode 2 slot
    localparam logic [15:0] XFER_LEN     = 16'd176; // Mode 3 slot
    localparam logic [7:0]  V_ACTIVE     = 8'd144;
    localparam logic [7:0]  V_SYNC_START = 8'd153;  // Active plus back porch
    localparam logic [7:0]  V_TOTAL      = 8'd154;

    //////////////////////////////
    // Fetch and display
    //////////////////////////////
    localparam int TILE_STEPS  = 8;
    localparam int VISIBLE_PIX = 160;
    localparam int FIFO_DEPTH  = 16;

    localparam logic [12:0] MAP_BASE_LO  = 13'h1800;
    localparam logic [12:0] MAP_BASE_HI  = 13'h1C00;
    localparam logic [12:0] TILE_BASE_LO = 13'h0800; // tile_sel = 0
    localparam logic [12:0] TILE_BASE_HI = 13'h0000; // tile_sel = 1

    //////////////////////////////
    // CPU bus map
    //////////////////////////////
    localparam logic [15:0] ADDR_LCDC = 16'hFF40;
    localparam logic [15:0] ADDR_STAT = 16'hFF41;
    localparam logic [15:0] ADDR_SCY  = 16'hFF42;
    localparam logic [15:0] ADDR_LY   = 16'hFF44;
    localparam logic [15:0] ADDR_LYC  = 16'hFF45;
    localparam logic [15:0] ADDR_BGP  = 16'hFF47;
    localparam logic [15:0] VRAM_LO   = 16'h8000;
    localparam logic [15:0] VRAM_HI   = 16'h9FFF;
    localparam logic [7:0]  BGP_RESET = 8'hFC;

    typedef enum logic [1:0] {
        HBLANK     = 2'd0,
        VBLANK     = 2'd1,
        OAM_SEARCH = 2'd2,
        XFER       = 2'd3
    } ppu_mode_t;

    // LCDC bit 7 down to bit 0
    typedef struct packed {
        logic lcd_en;
        logic win_map;  // Read back only
        logic win_en;   // Read back only
        logic tile_sel; // 1 selects tile data at 0x0000
        logic bg_map;   // 1 selects map at 0x1C00
        logic obj_size; // Read back only
        logic obj_en;   // Read back only
        logic bg_en;
    } lcdc_t;

    typedef struct packed {
        lcdc_t      lcdc;
        logic [7:0] scy;
        logic [7:0] bgp;
    } ppu_cfg_t;

    typedef struct packed {
        logic [8:0] h_count;
        logic [7:0] v_count;
        ppu_mode_t  mode;
    } line_pos_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rd;
        logic        wr;
    } bus_req_t;

    typedef struct packed {
        logic       load;
        logic [7:0] data_lo;
        logic [7:0] data_hi;
    } tile_row_t;

endpackage
